// ==== common/decode_config.svh ====
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// packet and datapath widths
`define DEC_PACKET_BYTES 16
`define DEC_MAX_PREFIXES 3
`define DEC_EIP_WIDTH    32
`define DEC_DATA_WIDTH   32
`define DEC_LEN_WIDTH    8

// legacy prefix bytes
`define DEC_PFX_REP    8'hF3
`define DEC_PFX_OPSIZE 8'h66
`define DEC_PFX_ES     8'h26
`define DEC_PFX_CS     8'h2E
`define DEC_PFX_SS     8'h36
`define DEC_PFX_DS     8'h3E
`define DEC_PFX_FS     8'h64
`define DEC_PFX_GS     8'h65

// reduced opcode table
`define DEC_OP_ESCAPE       8'h0F
`define DEC_OP_ADD_RM_R     8'h01
`define DEC_OP_ADD_R_RM     8'h03
`define DEC_OP_ADD_EAX_IMM  8'h05
`define DEC_OP_ALU_RM_IMM8  8'h83
`define DEC_OP_MOV_RM_R     8'h89
`define DEC_OP_MOV_R_RM     8'h8B
`define DEC_OP_MOV_RM_IMM   8'hC7
`define DEC_OP_MOV_R_IMM_HI 5'b10111 // B8..BF, low 3 bits are the register
`define DEC_OP_JMP_REL8     8'hEB
`define DEC_OP_JMP_REL32    8'hE9
`define DEC_OP_JZ_REL32     8'h84 // second byte after 0F
`define DEC_OP_NOP          8'h90

`endif

// ==== common/decode_pkg.sv ====
`default_nettype none

`include "decode_config.svh"

package decode_pkg;

    // byte 0 sits in the top bits, first byte of the instruction
    typedef logic [0:`DEC_PACKET_BYTES-1][7:0] packet_t;

    typedef logic [`DEC_LEN_WIDTH-1:0] len_t;

    typedef struct packed {
        logic       rep;
        logic       opsize_ovr;
        logic       seg_ovr;
        logic [2:0] seg_sel;      // ES=0 CS SS DS FS GS=5
        logic [1:0] num_prefixes;
    } prefix_info_t;

    // short form of an opcode byte, register in the low bits
    typedef struct packed {
        logic [4:0] hi;
        logic [2:0] reg_idx;
    } op_short_t;

    typedef union packed {
        logic [7:0] raw;
        op_short_t  short_form;
    } op_byte_u;

    typedef enum logic [2:0] {
        op_nop,
        op_alu,
        op_mov,
        op_branch,
        op_illegal
    } op_class_e;

    typedef enum logic [1:0] {
        imm_none,
        imm_byte,
        imm_full  // 4 bytes, 2 under opsize override
    } imm_size_e;

    typedef struct packed {
        op_class_e  op_class;
        logic       has_modrm;
        logic       is_double;  // 0F escape in front
        imm_size_e  imm_size;
        logic       is_br;
        logic [2:0] reg1;
    } opcode_info_t;

    typedef struct packed {
        logic       has_sib;
        logic [2:0] disp_size;  // 0, 1 or 4 bytes
        logic [2:0] reg2;       // rm or sib base
        logic       use_reg2;
        logic [2:0] reg3;       // sib index
        logic       use_reg3;
        logic [1:0] scale;
    } modrm_info_t;

    typedef struct packed {
        logic                      is_init;
        logic [`DEC_EIP_WIDTH-1:0] init_eip;
        logic                      is_resteer;
        logic [`DEC_EIP_WIDTH-1:0] wb_eip;
        logic                      is_br_taken;
        logic [`DEC_EIP_WIDTH-1:0] bp_eip;
    } ctrl_flow_t;

    typedef struct packed {
        len_t                       length;
        prefix_info_t               prefix;
        opcode_info_t               op;
        modrm_info_t                modrm;
        logic [`DEC_DATA_WIDTH-1:0] disp;
        logic [`DEC_DATA_WIDTH-1:0] imm;
    } decoded_t;

endpackage

`default_nettype wire

// ==== design/decode_top.sv ====
`default_nettype none

`include "decode_config.svh"

module decode_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      valid,
    input  decode_pkg::packet_t       packet,
    input  logic                      stall,        // queue full downstream
    input  decode_pkg::ctrl_flow_t    ctrl,
    output logic                      decode_valid,
    output decode_pkg::decoded_t      result,
    output logic [`DEC_EIP_WIDTH-1:0] eip_out,      // next sequential eip
    output logic [`DEC_EIP_WIDTH-1:0] latched_eip
);
    import decode_pkg::*;

    prefix_info_t              prefix;
    opcode_info_t              op;
    modrm_info_t               modrm;
    logic [`DEC_LEN_WIDTH-1:0] length;

    assign decode_valid = valid;

    //////////////////////////////////////////////////
    // combinational decode chain
    //////////////////////////////////////////////////
    prefix_decode u_prefix (
        .packet (packet),
        .prefix (prefix)
    );

    opcode_decode u_opcode (
        .packet (packet),
        .prefix (prefix),
        .op     (op)
    );

    modrm_decode u_modrm (
        .packet (packet),
        .prefix (prefix),
        .op     (op),
        .modrm  (modrm)
    );

    field_extract u_fields (
        .packet (packet),
        .prefix (prefix),
        .op     (op),
        .modrm  (modrm),
        .result (result),
        .length (length)
    );

    // eip register and redirect
    eip_tracker u_eip (
        .clk         (clk),
        .reset       (reset),
        .valid       (valid),
        .stall       (stall),
        .ctrl        (ctrl),
        .length      (length),
        .eip_out     (eip_out),
        .latched_eip (latched_eip)
    );

endmodule

`default_nettype wire

// ==== design/eip_tracker.sv ====
`default_nettype none

`include "decode_config.svh"

module eip_tracker (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       valid,
    input  logic                       stall,
    input  decode_pkg::ctrl_flow_t     ctrl,
    input  logic [`DEC_LEN_WIDTH-1:0]  length,
    output logic [`DEC_EIP_WIDTH-1:0]  eip_out,
    output logic [`DEC_EIP_WIDTH-1:0]  latched_eip
);
    import decode_pkg::*;

    logic                      is_cf;       // any control-flow strobe
    logic [`DEC_EIP_WIDTH-1:0] cf_eip;
    len_t                      gated_len;
    logic                      load;

    //////////////////////////////////////////////////
    // redirect select, init > resteer > taken branch
    //////////////////////////////////////////////////
    always_comb begin
        is_cf = ctrl.is_init | ctrl.is_resteer | ctrl.is_br_taken;
        if (ctrl.is_init) begin
            cf_eip = ctrl.init_eip;
        end else if (ctrl.is_resteer) begin
            cf_eip = ctrl.wb_eip;
        end else begin
            cf_eip = ctrl.bp_eip;
        end
    end

    // no advance on bubbles or redirects
    always_comb begin
        gated_len = (valid && !is_cf) ? length : '0;
        eip_out   = latched_eip + {{(`DEC_EIP_WIDTH-`DEC_LEN_WIDTH){1'b0}}, gated_len};
        load      = is_cf || (valid && !stall);  // strobes beat stall
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            latched_eip <= '0;
        end else if (load) begin
            latched_eip <= is_cf ? cf_eip : eip_out;
        end
    end

endmodule

`default_nettype wire

// ==== design/opcode_decode.sv ====
`default_nettype none

`include "decode_config.svh"

module opcode_decode (
    input  decode_pkg::packet_t      packet,
    input  decode_pkg::prefix_info_t prefix,
    output decode_pkg::opcode_info_t op
);
    import decode_pkg::*;

    logic [3:0] op_off;       // opcode sits right after the prefixes
    op_byte_u   op_byte;
    logic [7:0] second_byte;  // escape tail or modrm

    always_comb begin
        op_off      = {2'b00, prefix.num_prefixes};
        op_byte.raw = packet[op_off];
        second_byte = packet[op_off + 4'd1];
    end

    //////////////////////////////////////////////////
    // reduced table
    //////////////////////////////////////////////////
    always_comb begin
        op          = '0;
        op.op_class = op_illegal;  // one byte, no operands
        op.imm_size = imm_none;
        if (op_byte.short_form.hi == `DEC_OP_MOV_R_IMM_HI) begin
            // B8..BF, register folded into the opcode
            op.op_class = op_mov;
            op.imm_size = imm_full;
            op.reg1     = op_byte.short_form.reg_idx;
        end else begin
            case (op_byte.raw)
                `DEC_OP_ADD_RM_R, `DEC_OP_ADD_R_RM: begin
                    op.op_class  = op_alu;
                    op.has_modrm = 1'b1;
                    op.reg1      = second_byte[5:3];  // modrm.reg
                end
                `DEC_OP_MOV_RM_R, `DEC_OP_MOV_R_RM: begin
                    op.op_class  = op_mov;
                    op.has_modrm = 1'b1;
                    op.reg1      = second_byte[5:3];
                end
                `DEC_OP_ADD_EAX_IMM: begin
                    op.op_class = op_alu;
                    op.imm_size = imm_full;  // reg1 stays eax
                end
                `DEC_OP_ALU_RM_IMM8: begin
                    op.op_class  = op_alu;
                    op.has_modrm = 1'b1;
                    op.imm_size  = imm_byte;
                    op.reg1      = second_byte[5:3];  // group selector
                end
                `DEC_OP_MOV_RM_IMM: begin
                    op.op_class  = op_mov;
                    op.has_modrm = 1'b1;
                    op.imm_size  = imm_full;
                    op.reg1      = second_byte[5:3];
                end
                `DEC_OP_JMP_REL8: begin
                    op.op_class = op_branch;
                    op.imm_size = imm_byte;
                    op.is_br    = 1'b1;
                end
                `DEC_OP_JMP_REL32: begin
                    op.op_class = op_branch;
                    op.imm_size = imm_full;
                    op.is_br    = 1'b1;
                end
                `DEC_OP_ESCAPE: begin
                    // only jz rel32 lives behind the escape here
                    if (second_byte == `DEC_OP_JZ_REL32) begin
                        op.op_class  = op_branch;
                        op.is_double = 1'b1;
                        op.imm_size  = imm_full;
                        op.is_br     = 1'b1;
                    end
                end
                `DEC_OP_NOP: op.op_class = op_nop;
                default: ;  // illegal
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/operand/field_extract.sv ====
`default_nettype none

`include "decode_config.svh"

module field_extract (
    input  decode_pkg::packet_t       packet,
    input  decode_pkg::prefix_info_t  prefix,
    input  decode_pkg::opcode_info_t  op,
    input  decode_pkg::modrm_info_t   modrm,
    output decode_pkg::decoded_t      result,
    output logic [`DEC_LEN_WIDTH-1:0] length
);
    import decode_pkg::*;

    logic [2:0] imm_bytes;
    logic [4:0] disp_off;  // first displacement byte
    logic [4:0] imm_off;   // first immediate byte

    // little-endian gather of up to 4 bytes, then sign extension
    function automatic logic [`DEC_DATA_WIDTH-1:0] gather_le(
        input packet_t    pkt,
        input logic [4:0] base,
        input logic [2:0] nbytes
    );
        logic [31:0] raw;
        logic [4:0]  idx;
        raw = '0;
        for (int k = 0; k < 4; k++) begin
            idx = base + 5'(k);
            if (k < nbytes && idx < `DEC_PACKET_BYTES) begin
                raw[8*k +: 8] = pkt[idx[3:0]];
            end
        end
        case (nbytes)
            3'd1:    gather_le = {{24{raw[7]}}, raw[7:0]};
            3'd2:    gather_le = {{16{raw[15]}}, raw[15:0]};
            default: gather_le = raw;  // 4 bytes, or zero for none
        endcase
    endfunction

    //////////////////////////////////////////////////
    // length and field offsets
    //////////////////////////////////////////////////
    always_comb begin
        case (op.imm_size)
            imm_byte: imm_bytes = 3'd1;
            imm_full: imm_bytes = prefix.opsize_ovr ? 3'd2 : 3'd4;
            default:  imm_bytes = 3'd0;
        endcase
        disp_off = 5'(prefix.num_prefixes) + 5'd1 + 5'(op.is_double)
                 + 5'(op.has_modrm) + 5'(modrm.has_sib);
        imm_off  = disp_off + 5'(modrm.disp_size);
        length   = len_t'(imm_off) + len_t'(imm_bytes);  // at most 15
    end

    always_comb begin
        result        = '0;
        result.length = length;
        result.prefix = prefix;
        result.op     = op;
        result.modrm  = modrm;
        result.disp   = gather_le(packet, disp_off, modrm.disp_size);
        result.imm    = gather_le(packet, imm_off, imm_bytes);
    end

endmodule

`default_nettype wire

// ==== design/operand/modrm_decode.sv ====
`default_nettype none

module modrm_decode (
    input  decode_pkg::packet_t      packet,
    input  decode_pkg::prefix_info_t prefix,
    input  decode_pkg::opcode_info_t op,
    output decode_pkg::modrm_info_t  modrm
);
    import decode_pkg::*;

    logic [3:0] mrm_off;
    logic [7:0] mrm;     // mod[7:6] reg[5:3] rm[2:0]
    logic [7:0] sib;     // scale[7:6] index[5:3] base[2:0]

    always_comb begin
        mrm_off = {2'b00, prefix.num_prefixes} + 4'd1 + {3'b000, op.is_double};
        mrm     = packet[mrm_off];
        sib     = packet[mrm_off + 4'd1];
    end

    //////////////////////////////////////////////////
    // 32-bit addressing forms
    //////////////////////////////////////////////////
    always_comb begin
        modrm = '0;
        if (op.has_modrm) begin
            if (mrm[7:6] == 2'd3) begin
                modrm.reg2     = mrm[2:0];  // register direct
                modrm.use_reg2 = 1'b1;
            end else begin
                case (mrm[7:6])
                    2'd1:    modrm.disp_size = 3'd1;
                    2'd2:    modrm.disp_size = 3'd4;
                    default: modrm.disp_size = 3'd0;
                endcase
                if (mrm[2:0] == 3'd4) begin
                    modrm.has_sib = 1'b1;
                    modrm.scale   = sib[7:6];
                    if (sib[5:3] != 3'd4) begin  // index 4 means none
                        modrm.reg3     = sib[5:3];
                        modrm.use_reg3 = 1'b1;
                    end
                    if (sib[2:0] == 3'd5 && mrm[7:6] == 2'd0) begin
                        modrm.disp_size = 3'd4;  // disp32, no base
                    end else begin
                        modrm.reg2     = sib[2:0];
                        modrm.use_reg2 = 1'b1;
                    end
                end else if (mrm[7:6] == 2'd0 && mrm[2:0] == 3'd5) begin
                    modrm.disp_size = 3'd4;  // absolute disp32
                end else begin
                    modrm.reg2     = mrm[2:0];
                    modrm.use_reg2 = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/prefix_decode.sv ====
`default_nettype none

`include "decode_config.svh"

module prefix_decode (
    input  decode_pkg::packet_t      packet,
    output decode_pkg::prefix_info_t prefix
);
    import decode_pkg::*;

    logic       done;     // first non-prefix byte reached
    logic [3:0] seg_hit;  // {hit, sel}

    // segment prefix lookup, msb says it matched
    function automatic logic [3:0] seg_lookup(input logic [7:0] b);
        case (b)
            `DEC_PFX_ES: seg_lookup = 4'b1_000;
            `DEC_PFX_CS: seg_lookup = 4'b1_001;
            `DEC_PFX_SS: seg_lookup = 4'b1_010;
            `DEC_PFX_DS: seg_lookup = 4'b1_011;
            `DEC_PFX_FS: seg_lookup = 4'b1_100;
            `DEC_PFX_GS: seg_lookup = 4'b1_101;
            default:     seg_lookup = 4'b0_000;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // in-order scan of the leading bytes
    //////////////////////////////////////////////////
    always_comb begin
        prefix  = '0;
        done    = 1'b0;
        seg_hit = '0;
        for (int i = 0; i < `DEC_MAX_PREFIXES; i++) begin
            if (!done) begin
                seg_hit = seg_lookup(packet[i]);
                if (seg_hit[3]) begin
                    prefix.seg_ovr = 1'b1;
                    prefix.seg_sel = seg_hit[2:0];  // later one wins
                end else if (packet[i] == `DEC_PFX_REP) begin
                    prefix.rep = 1'b1;
                end else if (packet[i] == `DEC_PFX_OPSIZE) begin
                    prefix.opsize_ovr = 1'b1;
                end else begin
                    done = 1'b1;  // opcode starts here
                end
                if (!done) begin
                    prefix.num_prefixes = prefix.num_prefixes + 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+common
common/decode_pkg.sv
design/prefix_decode.sv
design/opcode_decode.sv
design/operand/modrm_decode.sv
design/operand/field_extract.sv
design/eip_tracker.sv
design/decode_top.sv
test/decode_checker.sv
test/decode_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module decode_tb -f project.f -o decode_sim

# the verdict comes from the pass line below, not the exit status
sim_out="$(./obj_dir/decode_sim 2>&1)" || true
echo "$sim_out"

if ! grep -qx "Finished with no errors" <<< "$sim_out"; then
    echo "run failed: pass line not found"
    exit 1
fi

// ==== test/decode_checker.sv ====
`default_nettype none

`include "decode_config.svh"

module decode_checker (
    input logic                      clk,
    input logic                      reset,
    input logic                      valid,
    input logic                      stall,
    input decode_pkg::ctrl_flow_t    ctrl,
    input decode_pkg::decoded_t      result,
    input logic [`DEC_EIP_WIDTH-1:0] latched_eip
);

    logic any_strobe;  // redirect of any kind

    assign any_strobe = ctrl.is_init | ctrl.is_resteer | ctrl.is_br_taken;

    //////////////////////////////////////////////////
    // decode and eip properties
    //////////////////////////////////////////////////

    // 15 bytes is the x86 ceiling
    length_limit: assert property (@(posedge clk) disable iff (reset)
        valid |-> result.length <= 8'd15)
        else $error("decoded length above 15 bytes");

    reset_clear: assert property (@(posedge clk)
        reset |=> latched_eip == '0)
        else $error("latched_eip not cleared by reset");

    stall_hold: assert property (@(posedge clk) disable iff (reset)
        (stall && !any_strobe) |=> $stable(latched_eip))  // no strobe, no move
        else $error("latched_eip moved under stall");

    init_load: assert property (@(posedge clk) disable iff (reset)
        ctrl.is_init |=> latched_eip == $past(ctrl.init_eip))
        else $error("latched_eip did not take init_eip");

endmodule

bind decode_top decode_checker i_checker (
    .clk         (clk),
    .reset       (reset),
    .valid       (valid),
    .stall       (stall),
    .ctrl        (ctrl),
    .result      (result),
    .latched_eip (latched_eip)
);

`default_nettype wire

// ==== test/decode_tb.sv ====
`default_nettype none

`include "decode_config.svh"

module decode_tb;
    import decode_pkg::*;

    localparam int n_tests        = 2000;
    localparam int reset_cycles   = 10;
    localparam int timeout_cycles = reset_cycles + n_tests * 2 + 100;

    // stimulus pools
    localparam logic [7:0] prefix_bytes [8] = '{
        8'hF3, 8'h66, 8'h26, 8'h2E, 8'h36, 8'h3E, 8'h64, 8'h65
    };
    localparam logic [7:0] table_ops [12] = '{
        8'h01, 8'h03, 8'h05, 8'h83, 8'h89, 8'h8B, 8'hC7, 8'hB8, 8'hEB, 8'hE9, 8'h0F, 8'h90
    };

    logic                      clk;
    logic                      reset;
    logic                      valid;
    packet_t                   packet;
    logic                      stall;
    ctrl_flow_t                ctrl;
    logic                      decode_valid;
    decoded_t                  result;
    logic [`DEC_EIP_WIDTH-1:0] eip_out;
    logic [`DEC_EIP_WIDTH-1:0] latched_eip;

    integer                    seed = 16578;
    int                        cycle_count = 0;
    decoded_t                  exp_result;
    logic                      any_strobe;
    logic [`DEC_EIP_WIDTH-1:0] model_eip;    // expected latched_eip
    logic [`DEC_EIP_WIDTH-1:0] exp_eip_out;
    logic [`DEC_EIP_WIDTH-1:0] next_eip;

    decode_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .valid        (valid),
        .packet       (packet),
        .stall        (stall),
        .ctrl         (ctrl),
        .decode_valid (decode_valid),
        .result       (result),
        .eip_out      (eip_out),
        .latched_eip  (latched_eip)
    );

    always #2 clk = ~clk;  // 4 unit period

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run still going after %0d cycles", timeout_cycles);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    // little-endian read, sign extended from the top byte read
    function automatic logic [31:0] read_le(input packet_t p, input logic [3:0] pos,
                                            input logic [2:0] nbytes);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < 4; k++) begin
            if (3'(k) < nbytes) v[8*k +: 8] = p[pos + 4'(k)];
        end
        if (nbytes == 3'd1) v = {{24{v[7]}}, v[7:0]};
        else if (nbytes == 3'd2) v = {{16{v[15]}}, v[15:0]};
        return v;
    endfunction

    function automatic decoded_t model_decode(input packet_t p);
        decoded_t   d;
        logic       stop;
        logic [1:0] n;
        logic [3:0] pos;     // running byte offset
        logic [7:0] opc;
        logic [7:0] mrm;
        logic [7:0] sib;
        logic [2:0] imm_n;
        d    = '0;
        stop = 1'b0;
        n    = 2'd0;
        for (int i = 0; i < 3; i++) begin
            if (!stop) begin
                case (p[4'(i)])
                    8'hF3:   d.prefix.rep = 1'b1;
                    8'h66:   d.prefix.opsize_ovr = 1'b1;
                    8'h26:   d.prefix.seg_sel = 3'd0;
                    8'h2E:   d.prefix.seg_sel = 3'd1;
                    8'h36:   d.prefix.seg_sel = 3'd2;
                    8'h3E:   d.prefix.seg_sel = 3'd3;
                    8'h64:   d.prefix.seg_sel = 3'd4;
                    8'h65:   d.prefix.seg_sel = 3'd5;
                    default: stop = 1'b1;  // scan ends at the opcode
                endcase
                if (p[4'(i)] inside {8'h26, 8'h2E, 8'h36, 8'h3E, 8'h64, 8'h65}) begin
                    d.prefix.seg_ovr = 1'b1;
                end
                if (!stop) n = n + 2'd1;
            end
        end
        d.prefix.num_prefixes = n;
        pos = {2'b00, n};
        opc = p[pos];
        d.op.op_class = op_illegal;
        if (opc[7:3] == 5'b10111) begin  // mov r32, imm
            d.op.op_class = op_mov;
            d.op.imm_size = imm_full;
            d.op.reg1     = opc[2:0];
        end else begin
            case (opc)
                8'h01, 8'h03: begin
                    d.op.op_class  = op_alu;
                    d.op.has_modrm = 1'b1;
                end
                8'h89, 8'h8B: begin
                    d.op.op_class  = op_mov;
                    d.op.has_modrm = 1'b1;
                end
                8'h05: begin
                    d.op.op_class = op_alu;
                    d.op.imm_size = imm_full;
                end
                8'h83: begin
                    d.op.op_class  = op_alu;
                    d.op.has_modrm = 1'b1;
                    d.op.imm_size  = imm_byte;
                end
                8'hC7: begin
                    d.op.op_class  = op_mov;
                    d.op.has_modrm = 1'b1;
                    d.op.imm_size  = imm_full;
                end
                8'hEB, 8'hE9: begin
                    d.op.op_class = op_branch;
                    d.op.is_br    = 1'b1;
                    d.op.imm_size = (opc == 8'hEB) ? imm_byte : imm_full;
                end
                8'h0F: begin
                    if (p[pos + 4'd1] == 8'h84) begin  // jz rel32
                        d.op.op_class  = op_branch;
                        d.op.is_br     = 1'b1;
                        d.op.is_double = 1'b1;
                        d.op.imm_size  = imm_full;
                    end
                end
                8'h90:   d.op.op_class = op_nop;
                default: ;
            endcase
        end
        pos = pos + 4'd1 + {3'b000, d.op.is_double};
        if (d.op.has_modrm) begin
            mrm       = p[pos];
            d.op.reg1 = mrm[5:3];
            pos       = pos + 4'd1;
            if (mrm[7:6] == 2'd3) begin
                d.modrm.reg2     = mrm[2:0];
                d.modrm.use_reg2 = 1'b1;
            end else begin
                if (mrm[7:6] == 2'd1) d.modrm.disp_size = 3'd1;
                else if (mrm[7:6] == 2'd2) d.modrm.disp_size = 3'd4;
                if (mrm[2:0] == 3'd4) begin
                    sib             = p[pos];
                    pos             = pos + 4'd1;
                    d.modrm.has_sib = 1'b1;
                    d.modrm.scale   = sib[7:6];
                    if (sib[5:3] != 3'd4) begin
                        d.modrm.reg3     = sib[5:3];
                        d.modrm.use_reg3 = 1'b1;
                    end
                    if (mrm[7:6] == 2'd0 && sib[2:0] == 3'd5) begin
                        d.modrm.disp_size = 3'd4;  // no base
                    end else begin
                        d.modrm.reg2     = sib[2:0];
                        d.modrm.use_reg2 = 1'b1;
                    end
                end else if (mrm[7:6] == 2'd0 && mrm[2:0] == 3'd5) begin
                    d.modrm.disp_size = 3'd4;
                end else begin
                    d.modrm.reg2     = mrm[2:0];
                    d.modrm.use_reg2 = 1'b1;
                end
            end
        end
        d.disp = read_le(p, pos, d.modrm.disp_size);
        pos    = pos + 4'(d.modrm.disp_size);
        if (d.op.imm_size == imm_byte) imm_n = 3'd1;
        else if (d.op.imm_size == imm_full) imm_n = d.prefix.opsize_ovr ? 3'd2 : 3'd4;
        else imm_n = 3'd0;
        d.imm    = read_le(p, pos, imm_n);
        d.length = {4'd0, pos} + {5'd0, imm_n};
        return d;
    endfunction

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    function automatic packet_t build_packet();
        packet_t     pkt;
        logic [31:0] rnd;
        logic [1:0]  n_pfx;
        logic [3:0]  pos;
        pkt   = {rand_word(), rand_word(), rand_word(), rand_word()};  // modrm, sib, data
        rnd   = rand_word();
        n_pfx = rnd[1:0];
        for (int i = 0; i < 3; i++) begin
            if (2'(i) < n_pfx) pkt[4'(i)] = prefix_bytes[rnd[4+3*i +: 3]];
        end
        pos = {2'b00, n_pfx};
        if (rnd[15:13] != 3'd0) begin  // mostly table opcodes
            pkt[pos] = table_ops[rnd[19:16] % 4'd12];
            if (pkt[pos] == 8'hB8) pkt[pos][2:0] = rnd[22:20];
            if (pkt[pos] == 8'h0F && rnd[25:23] != 3'd0) pkt[pos + 4'd1] = 8'h84;
        end
        return pkt;
    endfunction

    task automatic drive_cycle();
        logic [31:0] rnd;
        rnd              = rand_word();
        valid            = (rnd[2:0] != 3'd0);
        stall            = (rnd[5:3] == 3'd0);
        packet           = build_packet();
        ctrl             = '0;
        ctrl.is_init     = (rnd[9:6] == 4'd0);    // rare strobes
        ctrl.is_resteer  = (rnd[13:10] == 4'd0);
        ctrl.is_br_taken = (rnd[17:14] == 4'd0);
        ctrl.init_eip    = rand_word();
        ctrl.wb_eip      = rand_word();
        ctrl.bp_eip      = rand_word();
    endtask

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////
    task automatic check_decoded(input string name, input decoded_t got, input decoded_t exp);
        if (got !== exp) begin
            $display("FAIL %s got=%h exp=%h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "decoded fields differ from the model");
        end
    endtask

    task automatic check_eip(input string name, input logic [`DEC_EIP_WIDTH-1:0] got,
                             input logic [`DEC_EIP_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got=%h exp=%h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "eip differs from the model");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s got=%h exp=%h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "flag differs from the model");
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        valid     = 1'b0;
        packet    = '0;
        stall     = 1'b0;
        ctrl      = '0;
        model_eip = '0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int t = 0; t < n_tests; t++) begin
            check_eip("latched_eip", latched_eip, model_eip);  // result of last edge
            drive_cycle();
            #1;  // let the decode settle
            exp_result = model_decode(packet);
            check_flag("decode_valid", decode_valid, valid);
            check_decoded("result", result, exp_result);
            any_strobe  = ctrl.is_init | ctrl.is_resteer | ctrl.is_br_taken;
            exp_eip_out = model_eip;
            if (valid && !any_strobe) begin
                exp_eip_out = model_eip
                            + {{(`DEC_EIP_WIDTH-`DEC_LEN_WIDTH){1'b0}}, exp_result.length};
            end
            check_eip("eip_out", eip_out, exp_eip_out);
            if (ctrl.is_init) next_eip = ctrl.init_eip;
            else if (ctrl.is_resteer) next_eip = ctrl.wb_eip;
            else if (ctrl.is_br_taken) next_eip = ctrl.bp_eip;
            else if (valid && !stall) next_eip = exp_eip_out;
            else next_eip = model_eip;  // stall or bubble
            @(posedge clk);
            model_eip = next_eip;
            @(negedge clk);
        end
        check_eip("latched_eip", latched_eip, model_eip);
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
